/* rtl/dk_game_pkg.sv */
// Shared game constants and types; motion step, divider and cool-down widths are scaled for short simulation runs
package dk_game_pkg;

   localparam int COORD_W = 11;

   // Screen limits where barrels retire
   localparam logic [COORD_W-1:0] SCREEN_W = 11'd1024;
   localparam logic [COORD_W-1:0] SCREEN_H = 11'd768;

   localparam int BARRELS_PER_GROUP = 5;

   // Scaled down, real game moves much slower
   localparam logic [COORD_W-1:0] BARREL_STEP = 11'd64;
   localparam int MOVE_DIV   = 4;
   localparam int MOVE_DIV_W = $clog2(MOVE_DIV);

   // Launcher cool-down counter, wide enough for the scaled delays only
   localparam int COOLDOWN_W = 8;

   localparam logic [COORD_W-1:0] HIT_RADIUS    = 11'd32;
   localparam logic [COORD_W-1:0] PICKUP_RADIUS = 11'd32;

   localparam int HEALTH_W = 2;
   localparam logic [HEALTH_W-1:0] HEALTH_MAX = 2'd3;

   localparam logic [COORD_W-1:0] SHIELD_X = 11'd300;
   localparam logic [COORD_W-1:0] SHIELD_Y = 11'd468;

   typedef struct packed {
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
   } pos_t;

   typedef struct packed {
      logic start;
      logic up;
      logic down;
   } game_keys_t;

   typedef struct packed {
      logic                game_en;
      logic [HEALTH_W-1:0] health;
      logic                shielded;
   } game_status_t;

   // Box overlap, both distances strictly below radius
   function automatic logic near(input pos_t a, input pos_t b, input logic [COORD_W-1:0] radius);
      logic [COORD_W-1:0] dx;
      logic [COORD_W-1:0] dy;
      dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
      dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
      return (dx < radius) && (dy < radius);
   endfunction

endpackage

/* rtl/barrel_ctl.sv */
// Launcher for one barrel group; DELAY_TIME must fit COOLDOWN_W bits and be at least 2
`timescale 1ns/1ns

module barrel_ctl
   import dk_game_pkg::*;
#(
   parameter int DELAY_TIME = 40
) (
   input  logic                         clk65MHz,
   input  logic                         arst_n,
   input  logic                         game_en,
   input  logic                         key,
   input  logic [BARRELS_PER_GROUP-1:0] slot_active,
   output logic [BARRELS_PER_GROUP-1:0] launch
);

   logic [COOLDOWN_W-1:0]        cool_cnt;
   logic [BARRELS_PER_GROUP-1:0] free_slots;
   logic [BARRELS_PER_GROUP-1:0] pick;
   logic                         fire;

   // Lowest free slot as one-hot
   always_comb begin
      free_slots = ~slot_active;
      pick       = free_slots & (~free_slots + 1'b1);
      fire       = key && game_en && (cool_cnt == '0) && (|free_slots);
   end

   always_ff @(posedge clk65MHz or negedge arst_n) begin
      if (!arst_n) begin
         launch   <= '0;
         cool_cnt <= '0;
      end else begin
         launch <= '0;
         if (fire) begin
            launch   <= pick;
            cool_cnt <= COOLDOWN_W'(DELAY_TIME);
         end else if (cool_cnt != '0) begin
            cool_cnt <= cool_cnt - 1'b1;
         end
      end
   end

endmodule

/* rtl/barrel_track.sv */
// One barrel moving from Kong along x (VERTICAL=0) or y (VERTICAL=1); a hit can skip a 1-pixel gap at step 64
`timescale 1ns/1ns

module barrel_track
   import dk_game_pkg::*;
#(
   parameter bit VERTICAL = 1'b0
) (
   input  logic clk65MHz,
   input  logic arst_n,
   input  logic game_en,
   input  logic launch,
   input  pos_t kong_pos,
   input  pos_t donkey_pos,
   output logic active,
   output logic hit
);

   pos_t                  pos;
   logic [MOVE_DIV_W-1:0] div_cnt;
   logic                  tick;
   logic [COORD_W:0]      coord_next;
   logic [COORD_W:0]      limit;
   logic                  overlap;

   always_comb begin
      tick    = (div_cnt == MOVE_DIV_W'(MOVE_DIV - 1));
      overlap = near(pos, donkey_pos, HIT_RADIUS);
      if (VERTICAL) begin
         coord_next = {1'b0, pos.y} + {1'b0, BARREL_STEP};
         limit      = {1'b0, SCREEN_H};
      end else begin
         coord_next = {1'b0, pos.x} + {1'b0, BARREL_STEP};
         limit      = {1'b0, SCREEN_W};
      end
   end

   // Position register
   always_ff @(posedge clk65MHz) begin
      if (launch) begin
         pos <= kong_pos;
      end else if (active && tick) begin
         if (VERTICAL)
            pos.y <= coord_next[COORD_W-1:0];
         else
            pos.x <= coord_next[COORD_W-1:0];
      end
   end

   always_ff @(posedge clk65MHz or negedge arst_n) begin
      if (!arst_n) begin
         active  <= 1'b0;
         hit     <= 1'b0;
         div_cnt <= '0;
      end else begin
         hit <= 1'b0;
         if (!game_en) begin
            active <= 1'b0;
         end else if (launch) begin
            active  <= 1'b1;
            div_cnt <= '0;
         end else if (active) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (overlap) begin
               hit    <= 1'b1;
               active <= 1'b0;
            end else if (tick && (coord_next >= limit)) begin
               // Off screen
               active <= 1'b0;
            end
         end
      end
   end

endmodule

/* rtl/health_shielding.sv */
// Shield pickup once per game at SHIELD_X/SHIELD_Y; start re-arms it only while no game runs
`timescale 1ns/1ns

module health_shielding
   import dk_game_pkg::*;
(
   input  logic       clk65MHz,
   input  logic       arst_n,
   input  logic       game_en,
   input  logic       start,
   input  pos_t       donkey_pos,
   input  logic [9:0] hit,
   output logic       shielded,
   output logic       damage
);

   logic taken;
   logic at_shield;

   assign at_shield = near(donkey_pos, '{x: SHIELD_X, y: SHIELD_Y}, PICKUP_RADIUS);

   always_ff @(posedge clk65MHz or negedge arst_n) begin
      if (!arst_n) begin
         taken    <= 1'b0;
         shielded <= 1'b0;
         damage   <= 1'b0;
      end else begin
         damage <= 1'b0;
         if (start && !game_en) begin
            taken    <= 1'b0;
            shielded <= 1'b0;
         end else if (|hit) begin
            // Shield absorbs every hit of this cycle
            if (shielded)
               shielded <= 1'b0;
            else
               damage <= 1'b1;
         end else if (game_en && !taken && at_shield) begin
            taken    <= 1'b1;
            shielded <= 1'b1;
         end
      end
   end

endmodule

/* rtl/game_fsm.sv */
// Menu/play/over control; game_en falls one edge after health reaches zero
`timescale 1ns/1ns

module game_fsm
   import dk_game_pkg::*;
(
   input  logic                clk65MHz,
   input  logic                arst_n,
   input  logic                start,
   input  logic                damage,
   output logic                game_en,
   output logic [HEALTH_W-1:0] health
);

   typedef enum logic [1:0] {
      MENU,
      PLAY,
      OVER
   } state_t;

   state_t state;

   assign game_en = (state == PLAY);

   always_ff @(posedge clk65MHz or negedge arst_n) begin
      if (!arst_n) begin
         state  <= MENU;
         health <= HEALTH_MAX;
      end else begin
         case (state)
            MENU, OVER: begin
               if (start) begin
                  state  <= PLAY;
                  health <= HEALTH_MAX;
               end
            end
            PLAY: begin
               if (health == '0)
                  state <= OVER;
               else if (damage)
                  health <= health - 1'b1;
            end
            default: begin
               state <= MENU;
            end
         endcase
      end
   end

endmodule

/* rtl/donkey_kong_game.sv */
// Game core without video or keyboard; positions and one-cycle key pulses come from outside
`timescale 1ns/1ns

module donkey_kong_game
   import dk_game_pkg::*;
(
   input  logic         clk65MHz,
   input  logic         arst_n,
   input  game_keys_t   keys,
   input  pos_t         kong_pos,
   input  pos_t         donkey_pos,
   output game_status_t status,
   output logic [9:0]   barrel_active
);

   logic                         game_en;
   logic [HEALTH_W-1:0]          health;
   logic                         shielded;
   logic                         damage;
   logic [9:0]                   hit;
   logic [BARRELS_PER_GROUP-1:0] launch_hor;
   logic [BARRELS_PER_GROUP-1:0] launch_ver;

   assign status = '{game_en: game_en, health: health, shielded: shielded};

   // Horizontal group, bits 0-4
   barrel_ctl #(.DELAY_TIME(40)) u_barrel_ctl_hor (
      .clk65MHz,
      .arst_n,
      .game_en,
      .key(keys.up),
      .slot_active(barrel_active[4:0]),
      .launch(launch_hor)
   );

   // Vertical group, bits 5-9
   barrel_ctl #(.DELAY_TIME(20)) u_barrel_ctl_ver (
      .clk65MHz,
      .arst_n,
      .game_en,
      .key(keys.down),
      .slot_active(barrel_active[9:5]),
      .launch(launch_ver)
   );

   for (genvar i = 0; i < BARRELS_PER_GROUP; i++) begin : g_hor
      barrel_track #(.VERTICAL(1'b0)) u_barrel_track (
         .clk65MHz,
         .arst_n,
         .game_en,
         .launch(launch_hor[i]),
         .kong_pos,
         .donkey_pos,
         .active(barrel_active[i]),
         .hit(hit[i])
      );
   end

   for (genvar i = 0; i < BARRELS_PER_GROUP; i++) begin : g_ver
      barrel_track #(.VERTICAL(1'b1)) u_barrel_track (
         .clk65MHz,
         .arst_n,
         .game_en,
         .launch(launch_ver[i]),
         .kong_pos,
         .donkey_pos,
         .active(barrel_active[i+5]),
         .hit(hit[i+5])
      );
   end

   health_shielding u_health_shielding (
      .clk65MHz,
      .arst_n,
      .game_en,
      .start(keys.start),
      .donkey_pos,
      .hit,
      .shielded,
      .damage
   );

   game_fsm u_game_fsm (
      .clk65MHz,
      .arst_n,
      .start(keys.start),
      .damage,
      .game_en,
      .health
   );

endmodule

/* verification/donkey_kong_game_asserts.sv */
// Checks only while arst_n is high; shield rule looks at game_en one cycle before the rise
`timescale 1ns/1ns

module donkey_kong_game_asserts
   import dk_game_pkg::*;
(
   input logic         clk65MHz,
   input logic         arst_n,
   input game_status_t status,
   input logic [9:0]   barrel_active
);

   // Tracks clear one edge after game_en falls
   barrels_idle_when_stopped: assert property (
      @(posedge clk65MHz) disable iff (!arst_n)
      !status.game_en |=> (barrel_active == '0)
   ) else $error("barrel still active while the game is stopped");

   // Health only goes up when a new game restores it to the maximum
   health_only_restored: assert property (
      @(posedge clk65MHz) disable iff (!arst_n)
      (status.health > $past(status.health))
         |-> (!$past(status.game_en) && (status.health == HEALTH_MAX))
   ) else $error("health rose other than by a restart to its maximum");

   shield_only_in_game: assert property (
      @(posedge clk65MHz) disable iff (!arst_n)
      $rose(status.shielded) |-> $past(status.game_en)
   ) else $error("shield picked up while the game is stopped");

endmodule

bind donkey_kong_game donkey_kong_game_asserts donkey_kong_game_asserts_inst (
   .clk65MHz(clk65MHz),
   .arst_n(arst_n),
   .status(status),
   .barrel_active(barrel_active)
);

/* verification/donkey_kong_game_tb.sv */
// Kong stays at (64,100); random Donkey spots lie in x 600..855, y 600..727, clear of barrels and shield
`timescale 1ns/1ns

module donkey_kong_game_tb
   import dk_game_pkg::*;
;

   typedef struct packed {
      game_keys_t   keys;
      logic         rand_donkey;
      pos_t         kong;
      pos_t         donkey;
      logic [7:0]   wait_cycles;
      game_status_t exp_status;
      logic [9:0]   exp_active;
   } row_t;

   logic         clk65MHz;
   logic         arst_n;
   game_keys_t   keys;
   pos_t         kong_pos;
   pos_t         donkey_pos;
   game_status_t status;
   logic [9:0]   barrel_active;

   int errors = 0;
   int checks = 0;
   int seed   = 32'h69bb_44b2;

   // keys {start,up,down}, random Donkey, Kong, Donkey, wait, status {en,health,shield}, active
   row_t rows [13] = '{
      '{3'b000, 1'b1, '{11'd64, 11'd100}, '0, 8'd3, 4'b0_11_0, 10'h000},
      '{3'b010, 1'b0, '{11'd64, 11'd100}, '{SHIELD_X, SHIELD_Y}, 8'd4, 4'b0_11_0, 10'h000},
      '{3'b100, 1'b1, '{11'd64, 11'd100}, '0, 8'd2, 4'b1_11_0, 10'h000},
      '{3'b010, 1'b1, '{11'd64, 11'd100}, '0, 8'd4, 4'b1_11_0, 10'h001},
      '{3'b000, 1'b1, '{11'd64, 11'd100}, '0, 8'd70, 4'b1_11_0, 10'h000},
      '{3'b000, 1'b0, '{11'd64, 11'd100}, '{SHIELD_X, SHIELD_Y}, 8'd3, 4'b1_11_1, 10'h000},
      '{3'b000, 1'b1, '{11'd64, 11'd100}, '0, 8'd3, 4'b1_11_1, 10'h000},
      '{3'b010, 1'b0, '{11'd64, 11'd100}, '{11'd320, 11'd100}, 8'd30, 4'b1_11_0, 10'h000},
      '{3'b000, 1'b0, '{11'd64, 11'd100}, '{SHIELD_X, SHIELD_Y}, 8'd4, 4'b1_11_0, 10'h000},
      '{3'b001, 1'b0, '{11'd64, 11'd100}, '{11'd64, 11'd292}, 8'd30, 4'b1_10_0, 10'h000},
      '{3'b010, 1'b0, '{11'd64, 11'd100}, '{11'd320, 11'd100}, 8'd30, 4'b1_01_0, 10'h000},
      '{3'b001, 1'b0, '{11'd64, 11'd100}, '{11'd64, 11'd292}, 8'd30, 4'b0_00_0, 10'h000},
      '{3'b100, 1'b1, '{11'd64, 11'd100}, '0, 8'd3, 4'b1_11_0, 10'h000}
   };

   donkey_kong_game donkey_kong_game_inst (
      .clk65MHz,
      .arst_n,
      .keys,
      .kong_pos,
      .donkey_pos,
      .status,
      .barrel_active
   );

   initial begin
      clk65MHz = 1'b0;
      forever #20 clk65MHz = ~clk65MHz;
   end

   task automatic pick_far_spot(output pos_t p);
      p.x = 11'd600 + 11'($random(seed) & 32'hff);
      p.y = 11'd600 + 11'($random(seed) & 32'h7f);
   endtask

   task automatic check_row(input int idx, input row_t r);
      checks += 2;
      assert (status == r.exp_status)
      else begin
         errors++;
         $display("Fail at %0t ns: row %0d status %b, expected %b",
                  $time, idx, status, r.exp_status);
      end
      assert (barrel_active == r.exp_active)
      else begin
         errors++;
         $display("Fail at %0t ns: row %0d barrel_active %h, expected %h",
                  $time, idx, barrel_active, r.exp_active);
      end
   endtask

   initial begin
      row_t r;
      pos_t spot;
      arst_n     = 1'b0;
      keys       = '0;
      kong_pos   = '{x: 11'd64, y: 11'd100};
      donkey_pos = '{x: 11'd900, y: 11'd700};
      repeat (2) @(posedge clk65MHz);
      arst_n <= 1'b1;
      for (int i = 0; i < $size(rows); i++) begin
         r    = rows[i];
         spot = r.donkey;
         if (r.rand_donkey)
            pick_far_spot(spot);
         @(posedge clk65MHz);
         keys       <= r.keys;
         kong_pos   <= r.kong;
         donkey_pos <= spot;
         // Key pulses last one cycle
         @(posedge clk65MHz);
         keys <= '0;
         repeat (r.wait_cycles) @(posedge clk65MHz);
         @(negedge clk65MHz);
         check_row(i, r);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      int limit;
      int cycles;
      limit  = 64;
      cycles = 0;
      for (int i = 0; i < $size(rows); i++)
         limit += rows[i].wait_cycles + 3;
      while (cycles < limit) begin
         @(posedge clk65MHz);
         cycles++;
      end
      $display("Timeout: the stimulus table did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
   end

endmodule

/* donkey_kong_game.f */
rtl/dk_game_pkg.sv
rtl/barrel_ctl.sv
rtl/barrel_track.sv
rtl/health_shielding.sv
rtl/game_fsm.sv
rtl/donkey_kong_game.sv
verification/donkey_kong_game_asserts.sv
verification/donkey_kong_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
verilator --binary --timing --assert --top-module donkey_kong_game_tb \
   -f donkey_kong_game.f -o donkey_kong_game_sim \
   && ./obj_dir/donkey_kong_game_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "no result in log"; exit 1; }
exit 0
